// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_mini_core
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/mini_core_assertions.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module mini_core_assertions (
  input logic                   clk,
  input logic                   rst_ni,
  input logic                   instr_valid_i,
  input logic                   retire_valid_o,
  input logic                   retire_illegal_o,
  input logic [`REG_ADDR_W-1:0] retire_rd_o,
  input logic [`XLEN-1:0]       retire_wdata_o
);

  // Fixed pipeline latency of three cycles
  retire_latency: assert property (
    @(posedge clk) disable iff (!rst_ni) instr_valid_i |-> ##3 retire_valid_o
  ) else $error("retire_valid_o missing three cycles after instr_valid_i");

  illegal_needs_valid: assert property (
    @(posedge clk) disable iff (!rst_ni) retire_illegal_o |-> retire_valid_o
  ) else $error("retire_illegal_o raised without retire_valid_o");

  // Nothing is ever reported as written to x0
  x0_data_zero: assert property (
    @(posedge clk) disable iff (!rst_ni) (retire_rd_o == '0) |-> (retire_wdata_o == '0)
  ) else $error("retire_wdata_o nonzero for destination x0");

endmodule

bind mini_core mini_core_assertions i_assertions (
  .clk              (clk),
  .rst_ni           (rst_ni),
  .instr_valid_i    (instr_valid_i),
  .retire_valid_o   (retire_valid_o),
  .retire_illegal_o (retire_illegal_o),
  .retire_rd_o      (retire_rd_o),
  .retire_wdata_o   (retire_wdata_o)
);

// ==== bench/tb_mini_core.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module tb_mini_core;

  localparam int PERIOD    = 40;
  localparam int NUM_INSNS = 47;
  // Reset, drain gaps and pipeline fill
  localparam int MARGIN    = 100;

  typedef struct {
    int                     due;
    logic                   illegal;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       data;
  } retire_t;

  logic                   clk;
  logic                   rst_ni;
  logic                   instr_valid_i;
  logic [`XLEN-1:0]       instr_i;
  logic                   retire_valid_o;
  logic                   retire_illegal_o;
  logic [`REG_ADDR_W-1:0] retire_rd_o;
  logic [`XLEN-1:0]       retire_wdata_o;

  logic [`XLEN-1:0] ref_regs [`NUM_REGS];
  retire_t          exp_q [$];
  retire_t          got;
  int               cycle;
  int               errors = 0;
  int               checks = 0;
  int               seed   = 32'h9b91_88e8;

  mini_core i_dut (
    .clk              (clk),
    .rst_ni           (rst_ni),
    .instr_valid_i    (instr_valid_i),
    .instr_i          (instr_i),
    .retire_valid_o   (retire_valid_o),
    .retire_illegal_o (retire_illegal_o),
    .retire_rd_o      (retire_rd_o),
    .retire_wdata_o   (retire_wdata_o)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    #((NUM_INSNS + MARGIN) * PERIOD);
    $display("Watchdog expired before all instructions retired");
    $display("Testbench failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Instruction encoding and reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [`XLEN-1:0] rand_bits();
    return $random(seed);
  endfunction

  function automatic logic [`XLEN-1:0] r_insn(input logic [6:0] f7, input logic [2:0] f3,
                                               input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [4:0] rs2);
    core_pkg::insn_u w;
    w.r.funct7 = f7;
    w.r.rs2    = rs2;
    w.r.rs1    = rs1;
    w.r.funct3 = f3;
    w.r.rd     = rd;
    w.r.opcode = `OPCODE_OP;
    return w;
  endfunction

  function automatic logic [`XLEN-1:0] i_insn(input logic [2:0] f3, input logic [4:0] rd,
                                               input logic [4:0] rs1, input logic [11:0] imm);
    core_pkg::insn_u w;
    w.i.imm12  = imm;
    w.i.rs1    = rs1;
    w.i.funct3 = f3;
    w.i.rd     = rd;
    w.i.opcode = `OPCODE_OP_IMM;
    return w;
  endfunction

  // funct7 and funct3 of the ten register-register operations
  function automatic logic [9:0] r_funct(input int k);
    case (k)
      0: return {7'd0, `F3_ADD};
      1: return {`F7_ALT, `F3_ADD};
      2: return {7'd0, `F3_AND};
      3: return {7'd0, `F3_OR};
      4: return {7'd0, `F3_XOR};
      5: return {7'd0, `F3_SLT};
      6: return {7'd0, `F3_SLTU};
      7: return {7'd0, `F3_SLL};
      8: return {7'd0, `F3_SR};
      default: return {`F7_ALT, `F3_SR};
    endcase
  endfunction

  function automatic logic [2:0] imm_funct3(input int k);
    case (k)
      0: return `F3_ADD;
      1: return `F3_AND;
      2: return `F3_OR;
      3: return `F3_XOR;
      default: return `F3_SLT;
    endcase
  endfunction

  // Expected retire of one word from the ISA rules and the model registers
  function automatic retire_t predict(input logic [`XLEN-1:0] word);
    core_pkg::insn_u  w;
    retire_t          e;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic             alt;
    w   = word;
    a   = ref_regs[w.r.rs1];
    b   = {{(`XLEN - 12){w.i.imm12[11]}}, w.i.imm12};
    alt = 1'b0;
    if (w.r.opcode == `OPCODE_OP) begin
      b         = ref_regs[w.r.rs2];
      alt       = (w.r.funct7 == `F7_ALT);
      e.illegal = !(w.r.funct7 == 7'd0 ||
                    (alt && (w.r.funct3 == `F3_ADD || w.r.funct3 == `F3_SR)));
    end else if (w.r.opcode == `OPCODE_OP_IMM) begin
      e.illegal = (w.i.funct3 == `F3_SLL || w.i.funct3 == `F3_SR || w.i.funct3 == `F3_SLTU);
    end else begin
      e.illegal = 1'b1;
    end
    case (w.r.funct3)
      `F3_ADD:  e.data = alt ? a - b : a + b;
      `F3_SLL:  e.data = a << b[4:0];
      `F3_SLT:  e.data = {{(`XLEN - 1){1'b0}}, $signed(a) < $signed(b)};
      `F3_SLTU: e.data = {{(`XLEN - 1){1'b0}}, a < b};
      `F3_XOR:  e.data = a ^ b;
      `F3_SR:   e.data = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      `F3_OR:   e.data = a | b;
      default:  e.data = a & b;
    endcase
    e.rd = e.illegal ? '0 : w.r.rd;
    if (e.illegal || e.rd == '0) begin
      e.data = '0;
    end
    e.due = cycle + 3;
    return e;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Compare tasks and retire monitor
  //////////////////////////////////////////////////////////////////////

  task automatic check_retire(input logic [`REG_ADDR_W-1:0] exp_rd,
                              input logic [`XLEN-1:0] exp_data);
    checks++;
    if (retire_rd_o !== exp_rd || retire_wdata_o !== exp_data) begin
      errors++;
      $display("MISMATCH %0t: retired x%0d = %h, expected x%0d = %h",
               $time, retire_rd_o, retire_wdata_o, exp_rd, exp_data);
    end
  endtask

  task automatic check_illegal(input logic exp_illegal);
    checks++;
    if (retire_illegal_o !== exp_illegal) begin
      errors++;
      $display("MISMATCH %0t: illegal flag %b, expected %b",
               $time, retire_illegal_o, exp_illegal);
    end
  endtask

  // Retires first, so an issue in the same cycle sees their writes
  always @(negedge clk) begin
    if (!rst_ni) begin
      cycle = 0;
      for (int i = 0; i < `NUM_REGS; i++) begin
        ref_regs[i] = '0;
      end
    end else begin
      cycle++;
      if (retire_valid_o && exp_q.size() == 0) begin
        errors++;
        $display("Retire at %0t with no instruction in flight", $time);
      end else if (retire_valid_o) begin
        got = exp_q.pop_front();
        if (got.due != cycle) begin
          errors++;
          $display("Retire at %0t came in cycle %0d instead of %0d", $time, cycle, got.due);
        end
        check_illegal(got.illegal);
        check_retire(got.rd, got.data);
        if (!got.illegal && got.rd != '0) begin
          ref_regs[got.rd] = got.data;
        end
      end else if (exp_q.size() != 0 && exp_q[0].due <= cycle) begin
        errors++;
        $display("No retire at %0t for an instruction due in cycle %0d", $time, exp_q[0].due);
        exp_q.delete(0);
      end
      if (instr_valid_i) begin
        exp_q.push_back(predict(instr_i));
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus and directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic issue(input logic [`XLEN-1:0] word);
    @(posedge clk);
    instr_valid_i <= 1'b1;
    instr_i       <= word;
  endtask

  task automatic idle();
    @(posedge clk);
    instr_valid_i <= 1'b0;
  endtask

  // Wait until everything in flight has retired
  task automatic drain();
    idle();
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
  endtask

  task automatic imm_operations();
    logic [`XLEN-1:0] r;
    logic [11:0]      imm;
    for (int i = 1; i <= 4; i++) begin
      r = rand_bits();
      issue(i_insn(`F3_ADD, 5'(i), 5'd0, r[11:0]));
    end
    drain();
    // Odd passes force a negative immediate
    for (int k = 0; k < 10; k++) begin
      r   = rand_bits();
      imm = (k % 2 == 1) ? (r[11:0] | 12'h800) : r[11:0];
      issue(i_insn(imm_funct3(k / 2), 5'(5 + k), 5'(1 + k % 4), imm));
    end
    drain();
  endtask

  task automatic reg_operations();
    logic [`XLEN-1:0] r;
    logic [9:0]       op;
    r = rand_bits();
    issue(i_insn(`F3_ADD, 5'd1, 5'd0, r[11:0] | 12'h800));
    issue(i_insn(`F3_ADD, 5'd2, 5'd0, r[23:12]));
    r = rand_bits();
    issue(i_insn(`F3_ADD, 5'd3, 5'd0, r[11:0]));
    issue(i_insn(`F3_ADD, 5'd4, 5'd0, r[23:12] | 12'h800));
    // Shift amount above 31
    issue(i_insn(`F3_ADD, 5'd5, 5'd0, {r[31:25] | 7'h01, r[28:24]}));
    drain();
    for (int k = 0; k < 10; k++) begin
      op = r_funct(k);
      issue(r_insn(op[9:3], op[2:0], 5'(10 + k), (k % 2 == 1) ? 5'd1 : 5'd3,
                   (k >= 7) ? 5'd5 : 5'(2 + k % 3)));
    end
    drain();
  endtask

  task automatic back_to_back_stream();
    logic [`XLEN-1:0] r;
    logic [9:0]       op;
    for (int k = 0; k < 8; k++) begin
      r  = rand_bits();
      op = r_funct(int'(r[3:0]) % 10);
      issue(r_insn(op[9:3], op[2:0], 5'(16 + k), 5'(1 + r[6:4] % 5), 5'(1 + r[9:7] % 5)));
    end
    drain();
  endtask

  task automatic x0_write_and_read();
    issue(i_insn(`F3_ADD, 5'd0, 5'd1, 12'h123));
    drain();
    issue(r_insn(7'd0, `F3_ADD, 5'd24, 5'd0, 5'd0));
    issue(r_insn(7'd0, `F3_OR, 5'd25, 5'd0, 5'd2));
    drain();
  endtask

  task automatic illegal_words();
    logic [`XLEN-1:0] word;
    word      = i_insn(`F3_ADD, 5'd2, 5'd1, 12'h055);
    // Load opcode lies outside the kept groups
    word[6:0] = 7'b0000011;
    issue(word);
    issue(r_insn(7'b0000001, `F3_ADD, 5'd3, 5'd1, 5'd2));
    drain();
    issue(r_insn(7'd0, `F3_OR, 5'd26, 5'd2, 5'd0));
    issue(r_insn(7'd0, `F3_OR, 5'd27, 5'd3, 5'd0));
    drain();
  endtask

  task automatic stale_source_read();
    logic [`XLEN-1:0] r;
    r = rand_bits();
    issue(i_insn(`F3_ADD, 5'd28, 5'd0, r[11:0] | 12'h001));
    issue(r_insn(7'd0, `F3_ADD, 5'd29, 5'd28, 5'd0));
    idle();
    issue(r_insn(7'd0, `F3_ADD, 5'd30, 5'd28, 5'd0));
    drain();
  endtask

  initial begin
    rst_ni        = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    repeat (10) @(posedge clk);
    rst_ni <= 1'b1;
    imm_operations();
    reg_operations();
    back_to_back_stream();
    x0_write_and_read();
    illegal_words();
    stale_source_read();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+rtl
rtl/core_pkg.sv
rtl/exec_if.sv
rtl/regfile_read_if.sv
rtl/insn_decode.sv
rtl/alu_execute.sv
rtl/result_writeback.sv
rtl/mini_core.sv
bench/mini_core_assertions.sv
bench/tb_mini_core.sv

// ==== rtl/alu_execute.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module alu_execute (
  input  logic                   clk,
  input  logic                   rst_ni,
  exec_if.execute                ex_i,
  output logic                   res_valid_o,
  output logic [`REG_ADDR_W-1:0] res_rd_o,
  output logic [`XLEN-1:0]       res_data_o,
  output logic                   res_illegal_o
);

  logic [`XLEN-1:0] result;
  logic [4:0]       shamt;

  // Shifts use the low five bits only
  assign shamt = ex_i.operand_b[4:0];

  always_comb begin
    case (ex_i.alu_op)
      `ALU_ADD:  result = ex_i.operand_a + ex_i.operand_b;
      `ALU_SUB:  result = ex_i.operand_a - ex_i.operand_b;
      `ALU_AND:  result = ex_i.operand_a & ex_i.operand_b;
      `ALU_OR:   result = ex_i.operand_a | ex_i.operand_b;
      `ALU_XOR:  result = ex_i.operand_a ^ ex_i.operand_b;
      `ALU_SLT: begin
        result = {{(`XLEN - 1){1'b0}},
                  $signed(ex_i.operand_a) < $signed(ex_i.operand_b)};
      end
      `ALU_SLTU: begin
        result = {{(`XLEN - 1){1'b0}}, ex_i.operand_a < ex_i.operand_b};
      end
      `ALU_SLL:  result = ex_i.operand_a << shamt;
      `ALU_SRL:  result = ex_i.operand_a >> shamt;
      `ALU_SRA:  result = $unsigned($signed(ex_i.operand_a) >>> shamt);
      default:   result = '0;
    endcase
  end

  // Execute to write-back register
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= ex_i.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_i.valid) begin
      res_rd_o      <= ex_i.rd_addr;
      res_data_o    <= result;
      res_illegal_o <= ex_i.illegal;
    end
  end

endmodule

// ==== rtl/core_defines.svh ====
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Datapath and register file sizes
`define XLEN          32
`define REG_ADDR_W    5
`define NUM_REGS      32

// Major opcodes
`define OPCODE_W      7
`define OPCODE_OP     7'b0110011
`define OPCODE_OP_IMM 7'b0010011

// Funct3 codes of the integer groups
`define F3_ADD        3'b000
`define F3_SLL        3'b001
`define F3_SLT        3'b010
`define F3_SLTU       3'b011
`define F3_XOR        3'b100
`define F3_SR         3'b101
`define F3_OR         3'b110
`define F3_AND        3'b111

// Funct7 selecting sub and sra
`define F7_ALT        7'b0100000

// ALU operation codes
`define ALU_OP_W      4
`define ALU_ADD       4'd0
`define ALU_SUB       4'd1
`define ALU_AND       4'd2
`define ALU_OR        4'd3
`define ALU_XOR       4'd4
`define ALU_SLT       4'd5
`define ALU_SLTU      4'd6
`define ALU_SLL       4'd7
`define ALU_SRL       4'd8
`define ALU_SRA       4'd9

`endif

// ==== rtl/core_pkg.sv ====
`include "core_defines.svh"

package core_pkg;

  //////////////////////////////////////////////////////////////////////
  // Instruction word layouts
  //////////////////////////////////////////////////////////////////////

  // Register-register format
  typedef struct packed {
    logic [6:0]             funct7;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`OPCODE_W-1:0]   opcode;
  } insn_r_t;

  // Register-immediate format
  typedef struct packed {
    logic [11:0]            imm12;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`OPCODE_W-1:0]   opcode;
  } insn_i_t;

  // One fetched word viewed either way
  // Opcode, rd, funct3 and rs1 sit at the same bits in both views
  typedef union packed {
    insn_r_t r;
    insn_i_t i;
  } insn_u;

endpackage

// ==== rtl/exec_if.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

// One decoded operation on its way into execute
interface exec_if;
  logic                   valid;
  logic [`ALU_OP_W-1:0]   alu_op;
  logic [`XLEN-1:0]       operand_a;
  // Source register or sign-extended immediate
  logic [`XLEN-1:0]       operand_b;
  logic [`REG_ADDR_W-1:0] rd_addr;
  logic                   illegal;

  modport decode (
    output valid, alu_op, operand_a, operand_b, rd_addr, illegal
  );

  modport execute (
    input valid, alu_op, operand_a, operand_b, rd_addr, illegal
  );
endinterface

// ==== rtl/insn_decode.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module insn_decode (
  input  logic            clk,
  input  logic            rst_ni,
  input  logic            instr_valid_i,
  input  core_pkg::insn_u instr_i,
  regfile_read_if.reader  rf_o,
  exec_if.decode          ex_o
);

  logic [`ALU_OP_W-1:0]   alu_op;
  logic                   use_imm;
  logic                   illegal;
  logic [`XLEN-1:0]       imm_sext;
  logic [`REG_ADDR_W-1:0] rd_addr;

  // Source fields share their position in both views
  assign rf_o.raddr_a = instr_i.r.rs1;
  assign rf_o.raddr_b = instr_i.r.rs2;

  assign imm_sext = {{(`XLEN - 12){instr_i.i.imm12[11]}}, instr_i.i.imm12};

  //////////////////////////////////////////////////////////////////////
  // Opcode and funct decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    alu_op  = `ALU_ADD;
    use_imm = 1'b0;
    illegal = 1'b0;
    case (instr_i.r.opcode)
      `OPCODE_OP: begin
        if (instr_i.r.funct7 == '0) begin
          case (instr_i.r.funct3)
            `F3_ADD:  alu_op = `ALU_ADD;
            `F3_SLL:  alu_op = `ALU_SLL;
            `F3_SLT:  alu_op = `ALU_SLT;
            `F3_SLTU: alu_op = `ALU_SLTU;
            `F3_XOR:  alu_op = `ALU_XOR;
            `F3_SR:   alu_op = `ALU_SRL;
            `F3_OR:   alu_op = `ALU_OR;
            default:  alu_op = `ALU_AND;
          endcase
        end else if (instr_i.r.funct7 == `F7_ALT && instr_i.r.funct3 == `F3_ADD) begin
          alu_op = `ALU_SUB;
        end else if (instr_i.r.funct7 == `F7_ALT && instr_i.r.funct3 == `F3_SR) begin
          alu_op = `ALU_SRA;
        end else begin
          illegal = 1'b1;
        end
      end
      `OPCODE_OP_IMM: begin
        use_imm = 1'b1;
        // Only addi, slti, xori, ori and andi
        case (instr_i.i.funct3)
          `F3_ADD: alu_op = `ALU_ADD;
          `F3_SLT: alu_op = `ALU_SLT;
          `F3_XOR: alu_op = `ALU_XOR;
          `F3_OR:  alu_op = `ALU_OR;
          `F3_AND: alu_op = `ALU_AND;
          default: illegal = 1'b1;
        endcase
      end
      default: illegal = 1'b1;
    endcase
  end

  // Illegal words never name a destination
  assign rd_addr = illegal ? '0 : instr_i.r.rd;

  //////////////////////////////////////////////////////////////////////
  // Decode to execute register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      ex_o.valid <= 1'b0;
    end else begin
      ex_o.valid <= instr_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (instr_valid_i) begin
      ex_o.alu_op    <= alu_op;
      ex_o.operand_a <= rf_o.rdata_a;
      ex_o.operand_b <= use_imm ? imm_sext : rf_o.rdata_b;
      ex_o.rd_addr   <= rd_addr;
      ex_o.illegal   <= illegal;
    end
  end

endmodule

// ==== rtl/mini_core.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module mini_core (
  input  logic                   clk,
  input  logic                   rst_ni,
  input  logic                   instr_valid_i,
  input  logic [`XLEN-1:0]       instr_i,
  output logic                   retire_valid_o,
  output logic                   retire_illegal_o,
  output logic [`REG_ADDR_W-1:0] retire_rd_o,
  output logic [`XLEN-1:0]       retire_wdata_o
);

  // Execute to write-back link
  logic                   res_valid;
  logic [`REG_ADDR_W-1:0] res_rd;
  logic [`XLEN-1:0]       res_data;
  logic                   res_illegal;

  exec_if         ex_bus ();
  regfile_read_if rf_bus ();

  //////////////////////////////////////////////////////////////////////
  // Pipeline stages
  //////////////////////////////////////////////////////////////////////

  insn_decode i_decode (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid_i),
    .instr_i       (core_pkg::insn_u'(instr_i)),
    .rf_o          (rf_bus.reader),
    .ex_o          (ex_bus.decode)
  );

  alu_execute i_execute (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .ex_i          (ex_bus.execute),
    .res_valid_o   (res_valid),
    .res_rd_o      (res_rd),
    .res_data_o    (res_data),
    .res_illegal_o (res_illegal)
  );

  result_writeback i_writeback (
    .clk              (clk),
    .rst_ni           (rst_ni),
    .res_valid_i      (res_valid),
    .res_rd_i         (res_rd),
    .res_data_i       (res_data),
    .res_illegal_i    (res_illegal),
    .rf_i             (rf_bus.file),
    .retire_valid_o   (retire_valid_o),
    .retire_illegal_o (retire_illegal_o),
    .retire_rd_o      (retire_rd_o),
    .retire_wdata_o   (retire_wdata_o)
  );

endmodule

// ==== rtl/regfile_read_if.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

// Two asynchronous register file read ports
interface regfile_read_if;
  logic [`REG_ADDR_W-1:0] raddr_a;
  logic [`REG_ADDR_W-1:0] raddr_b;
  logic [`XLEN-1:0]       rdata_a;
  logic [`XLEN-1:0]       rdata_b;

  modport reader (output raddr_a, raddr_b, input rdata_a, rdata_b);

  modport file (input raddr_a, raddr_b, output rdata_a, rdata_b);
endinterface

// ==== rtl/result_writeback.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module result_writeback (
  input  logic                   clk,
  input  logic                   rst_ni,
  input  logic                   res_valid_i,
  input  logic [`REG_ADDR_W-1:0] res_rd_i,
  input  logic [`XLEN-1:0]       res_data_i,
  input  logic                   res_illegal_i,
  regfile_read_if.file           rf_i,
  output logic                   retire_valid_o,
  output logic                   retire_illegal_o,
  output logic [`REG_ADDR_W-1:0] retire_rd_o,
  output logic [`XLEN-1:0]       retire_wdata_o
);

  logic [`XLEN-1:0] regs [`NUM_REGS];
  logic             we;

  // x0 is never written, so it keeps its reset value of zero
  assign we = res_valid_i & ~res_illegal_i & (res_rd_i != '0);

  assign rf_i.rdata_a = regs[rf_i.raddr_a];
  assign rf_i.rdata_b = regs[rf_i.raddr_b];

  // Register file and retire report
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
      retire_valid_o   <= 1'b0;
      retire_illegal_o <= 1'b0;
      retire_rd_o      <= '0;
      retire_wdata_o   <= '0;
    end else begin
      if (we) begin
        regs[res_rd_i] <= res_data_i;
      end
      retire_valid_o   <= res_valid_i;
      retire_illegal_o <= res_valid_i & res_illegal_i;
      retire_rd_o      <= res_valid_i ? res_rd_i : '0;
      // Report the value that was actually written
      retire_wdata_o   <= we ? res_data_i : '0;
    end
  end

endmodule
